//--- batch_join_ctrl.sv
`timescale 1ns/1ps
`include "pkt_join_cfg.svh"

module batch_join_ctrl import pkt_join_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           operation_start,
  input  logic [`PJ_BATCH-1:0]           use_batch,
  input  logic                           interrupt,
  input  lane_state_e [`PJ_BATCH-1:0]    lane_state,
  input  logic [`PJ_BATCH-1:0]           lane_fault,
  input  logic                           m_tvalid,
  input  logic                           m_tready,
  output logic [`PJ_BATCH-1:0]           lane_start,
  output logic                           lane_abort,
  output logic                           operation_busy,
  output logic                           operation_complete,
  output logic                           operation_error,
  output logic                           transmission
);

  logic [`PJ_BATCH-1:0] active_mask;
  logic [`PJ_BATCH-1:0] done_mask;
  logic [`PJ_BATCH-1:0] lane_done;
  logic [`PJ_BATCH-1:0] done_next;
  logic                 start_req;
  logic                 empty_start;
  logic                 all_done;

  // Starts are only taken while idle
  assign start_req   = operation_start && !operation_busy;
  assign empty_start = start_req && (use_batch == '0);
  assign lane_start  = start_req ? use_batch : '0;

  // Interrupt only matters during an operation
  assign lane_abort = interrupt && operation_busy;

  assign transmission = m_tvalid && m_tready;

  always_comb begin
    for (int i = 0; i < `PJ_BATCH; i++) begin
      lane_done[i] = (lane_state[i] == DONE);
    end
  end

  // A lane sits in DONE for one cycle only, so remember it here
  assign done_next = done_mask | (lane_done & active_mask);
  assign all_done  = (done_next == active_mask);

  always_ff @(posedge clk) begin
    if (rst) begin
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      active_mask        <= '0;
      done_mask          <= '0;
    end else begin
      operation_complete <= 1'b0;
      operation_error    <= empty_start || (|lane_fault) || lane_abort;
      if (lane_abort) begin
        operation_busy <= 1'b0;
        done_mask      <= '0;
      end else if (operation_busy) begin
        if (all_done) begin
          operation_busy     <= 1'b0;
          operation_complete <= 1'b1;
          done_mask          <= '0;
        end else begin
          done_mask <= done_next;
        end
      end else if ((|lane_start) && !(|lane_fault)) begin
        // Lanes that fault on start never leave IDLE, so stay idle too
        operation_busy <= 1'b1;
        active_mask    <= use_batch;
        done_mask      <= '0;
      end
    end
  end

endmodule

//--- batched_packet_joiner.sv
`timescale 1ns/1ps
`include "pkt_join_cfg.svh"

module batched_packet_joiner import pkt_join_pkg::*; (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           operation_start,
  input  logic [`PJ_CHANNELS-1:0]                        use_channels,
  input  logic [`PJ_BATCH-1:0]                           use_batch,
  input  logic                                           interrupt,
  output logic                                           operation_busy,
  output logic                                           operation_complete,
  output logic                                           operation_error,
  output logic                                           transmission,
  input  logic [`PJ_BATCH*`PJ_CHANNELS*`PJ_DATA_W-1:0]   s_tdata,
  input  logic [`PJ_BATCH*`PJ_CHANNELS*`PJ_KEEP_W-1:0]   s_tkeep,
  input  logic [`PJ_BATCH*`PJ_CHANNELS-1:0]              s_tvalid,
  output logic [`PJ_BATCH*`PJ_CHANNELS-1:0]              s_tready,
  input  logic [`PJ_BATCH*`PJ_CHANNELS-1:0]              s_tlast,
  input  logic [`PJ_BATCH*`PJ_CHANNELS*`PJ_ID_W-1:0]     s_tid,
  output logic [`PJ_DATA_W-1:0]                          m_tdata,
  output logic [`PJ_KEEP_W-1:0]                          m_tkeep,
  output logic                                           m_tvalid,
  input  logic                                           m_tready,
  output logic                                           m_tlast,
  output logic [`PJ_MID_W-1:0]                           m_tid
);

  localparam int CH = `PJ_CHANNELS;

  logic [`PJ_BATCH-1:0]             lane_start;
  logic                             lane_abort;
  lane_state_e [`PJ_BATCH-1:0]      lane_state;
  logic [`PJ_BATCH-1:0]             lane_fault;
  logic [`PJ_BATCH*`PJ_DATA_W-1:0]  lane_tdata;
  logic [`PJ_BATCH*`PJ_KEEP_W-1:0]  lane_tkeep;
  logic [`PJ_BATCH-1:0]             lane_tvalid;
  logic [`PJ_BATCH-1:0]             lane_tready;
  logic [`PJ_BATCH-1:0]             lane_tlast;
  logic [`PJ_BATCH*`PJ_ID_W-1:0]    lane_tid;

  batch_join_ctrl ctrl0 (
    .clk                (clk),
    .rst                (rst),
    .operation_start    (operation_start),
    .use_batch          (use_batch),
    .interrupt          (interrupt),
    .lane_state         (lane_state),
    .lane_fault         (lane_fault),
    .m_tvalid           (m_tvalid),
    .m_tready           (m_tready),
    .lane_start         (lane_start),
    .lane_abort         (lane_abort),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .transmission       (transmission)
  );

  // Every lane shares the channel selection
  for (genvar g = 0; g < `PJ_BATCH; g++) begin : g_lane
    lane_joiner lane0 (
      .clk          (clk),
      .rst          (rst),
      .lane_start   (lane_start[g]),
      .lane_abort   (lane_abort),
      .use_channels (use_channels),
      .s_tdata      (s_tdata[g*CH*`PJ_DATA_W +: CH*`PJ_DATA_W]),
      .s_tkeep      (s_tkeep[g*CH*`PJ_KEEP_W +: CH*`PJ_KEEP_W]),
      .s_tvalid     (s_tvalid[g*CH +: CH]),
      .s_tlast      (s_tlast[g*CH +: CH]),
      .s_tid        (s_tid[g*CH*`PJ_ID_W +: CH*`PJ_ID_W]),
      .s_tready     (s_tready[g*CH +: CH]),
      .lane_tdata   (lane_tdata[g*`PJ_DATA_W +: `PJ_DATA_W]),
      .lane_tkeep   (lane_tkeep[g*`PJ_KEEP_W +: `PJ_KEEP_W]),
      .lane_tvalid  (lane_tvalid[g]),
      .lane_tlast   (lane_tlast[g]),
      .lane_tid     (lane_tid[g*`PJ_ID_W +: `PJ_ID_W]),
      .lane_tready  (lane_tready[g]),
      .lane_state   (lane_state[g]),
      .lane_fault   (lane_fault[g])
    );
  end

  lane_arb_mux mux0 (
    .clk         (clk),
    .rst         (rst),
    .lane_tdata  (lane_tdata),
    .lane_tkeep  (lane_tkeep),
    .lane_tvalid (lane_tvalid),
    .lane_tlast  (lane_tlast),
    .lane_tid    (lane_tid),
    .lane_tready (lane_tready),
    .m_tdata     (m_tdata),
    .m_tkeep     (m_tkeep),
    .m_tvalid    (m_tvalid),
    .m_tlast     (m_tlast),
    .m_tid       (m_tid),
    .m_tready    (m_tready)
  );

endmodule

//--- batched_packet_joiner_tb.sv
`timescale 1ns/1ps
`include "pkt_join_cfg.svh"

module batched_packet_joiner_tb;

  localparam int CH = `PJ_CHANNELS;
  localparam int NS = `PJ_BATCH * `PJ_CHANNELS;
  localparam int MAX_CYCLES = 4000;

  logic clk;
  logic rst;
  logic operation_start;
  logic [CH-1:0] use_channels;
  logic [`PJ_BATCH-1:0] use_batch;
  logic interrupt;
  logic operation_busy;
  logic operation_complete;
  logic operation_error;
  logic transmission;
  logic [NS*`PJ_DATA_W-1:0] s_tdata;
  logic [NS*`PJ_KEEP_W-1:0] s_tkeep;
  logic [NS-1:0] s_tvalid;
  logic [NS-1:0] s_tready;
  logic [NS-1:0] s_tlast;
  logic [NS*`PJ_ID_W-1:0] s_tid;
  logic [`PJ_DATA_W-1:0] m_tdata;
  logic [`PJ_KEEP_W-1:0] m_tkeep;
  logic m_tvalid;
  logic m_tready;
  logic m_tlast;
  logic [`PJ_MID_W-1:0] m_tid;

  // Source beat is {last, id, keep, data}, sink beat is {last, tid, keep, data}
  logic [22:0] src_q [NS][$];
  logic [23:0] exp_q [$];
  logic [23:0] sink_q [$];

  logic [31:0] rng_state = 32'd53097;
  logic [31:0] bp_rand;
  int bp_mode;
  int errors;
  int tests_run;
  int tests_passed;
  int cycles;
  int cnt_complete;
  int cnt_error;
  int cnt_trans;
  logic busy_seen;
  logic ch0_seen;
  string cur_test;

  batched_packet_joiner dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Handshakes are taken from pre-edge values
  always @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < NS; k++) begin
        if (s_tvalid[k] && s_tready[k]) begin
          void'(src_q[k].pop_front());
        end
      end
      if (m_tvalid && m_tready) begin
        sink_q.push_back({m_tlast, m_tid, m_tkeep, m_tdata});
      end
      check({cur_test, " transmission"}, m_tvalid && m_tready, transmission);
      if (transmission) cnt_trans++;
      if (operation_complete) cnt_complete++;
      if (operation_error) cnt_error++;
      if (operation_busy) busy_seen = 1'b1;
      if (s_tready[0]) ch0_seen = 1'b1;
    end
  end

  always @(negedge clk) begin
    for (int k = 0; k < NS; k++) begin
      if (src_q[k].size() > 0) begin
        {s_tlast[k], s_tid[k*`PJ_ID_W +: `PJ_ID_W], s_tkeep[k*`PJ_KEEP_W +: `PJ_KEEP_W],
         s_tdata[k*`PJ_DATA_W +: `PJ_DATA_W]} = src_q[k][0];
        s_tvalid[k] = 1'b1;
      end else begin
        s_tvalid[k] = 1'b0;
        s_tlast[k]  = 1'b0;
      end
    end
    if (bp_mode == 0) begin
      m_tready = 1'b1;
    end else if (bp_mode == 1) begin
      bp_rand  = next_rand();
      m_tready = bp_rand[3];
    end else begin
      m_tready = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Queue one channel's packet, and its expected output when selected
  task automatic queue_channel(input int lane, input int ch, input int nbeats,
                               input logic expect_out, input logic final_ch);
    logic [3:0] id;
    logic [15:0] data;
    logic [1:0] keep;
    logic last;
    logic [31:0] r;
    id = 4'(lane * 4 + ch + 5);
    for (int b = 0; b < nbeats; b++) begin
      r    = next_rand();
      data = r[15:0];
      r    = next_rand();
      keep = r[1:0];
      last = (b == nbeats - 1);
      src_q[lane*CH+ch].push_back({last, id, keep, data});
      if (expect_out) begin
        exp_q.push_back({last && final_ch, 1'(lane), id, keep, data});
      end
    end
  endtask

  task automatic start_op(input logic [`PJ_BATCH-1:0] batch, input logic [CH-1:0] chans);
    @(negedge clk);
    use_batch       = batch;
    use_channels    = chans;
    operation_start = 1'b1;
    @(negedge clk);
    operation_start = 1'b0;
  endtask

  task automatic wait_complete(input int c0);
    while (cnt_complete == c0) @(posedge clk);
    repeat (3) @(posedge clk);
  endtask

  task automatic compare_sink(input string name);
    check({name, " beat count"}, exp_q.size(), sink_q.size());
    for (int i = 0; i < exp_q.size() && i < sink_q.size(); i++) begin
      check({name, " beat"}, exp_q[i], sink_q[i]);
    end
    exp_q.delete();
    sink_q.delete();
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      tests_passed++;
      $display("%s finished, no errors", name);
    end else begin
      $display("%s finished, %0d errors", name, errors - err0);
    end
  endtask

  task automatic single_lane_test();
    int err0, c0;
    err0 = errors;
    cur_test = "single_lane";
    c0 = cnt_complete;
    @(posedge clk);
    queue_channel(0, 0, 3, 1'b1, 1'b0);
    queue_channel(0, 1, 4, 1'b1, 1'b1);
    start_op(2'b01, 2'b11);
    wait_complete(c0);
    check("single_lane complete count", 1, cnt_complete - c0);
    compare_sink("single_lane");
    finish_test("single_lane", err0);
  endtask

  task automatic both_lanes_test();
    int err0, c0;
    err0 = errors;
    cur_test = "both_lanes";
    c0 = cnt_complete;
    @(posedge clk);
    // Lane 0 wins the first grant, so its beats come first
    queue_channel(0, 0, 2, 1'b1, 1'b0);
    queue_channel(0, 1, 3, 1'b1, 1'b1);
    queue_channel(1, 0, 4, 1'b1, 1'b0);
    queue_channel(1, 1, 2, 1'b1, 1'b1);
    start_op(2'b11, 2'b11);
    wait_complete(c0);
    check("both_lanes complete count", 1, cnt_complete - c0);
    compare_sink("both_lanes");
    finish_test("both_lanes", err0);
  endtask

  task automatic backpressure_test();
    int err0, c0, t0, nexp;
    err0 = errors;
    cur_test = "backpressure";
    c0 = cnt_complete;
    t0 = cnt_trans;
    @(posedge clk);
    queue_channel(1, 0, 6, 1'b1, 1'b0);
    queue_channel(1, 1, 5, 1'b1, 1'b1);
    nexp = exp_q.size();
    bp_mode = 1;
    start_op(2'b10, 2'b11);
    wait_complete(c0);
    bp_mode = 0;
    check("backpressure transfers", nexp, cnt_trans - t0);
    compare_sink("backpressure");
    finish_test("backpressure", err0);
  endtask

  task automatic skip_channel_test();
    int err0, c0;
    err0 = errors;
    cur_test = "skip_channel";
    c0 = cnt_complete;
    @(posedge clk);
    ch0_seen = 1'b0;
    queue_channel(0, 0, 3, 1'b0, 1'b0);
    queue_channel(0, 1, 4, 1'b1, 1'b1);
    start_op(2'b01, 2'b10);
    wait_complete(c0);
    check("skip_channel ch0 tready", 0, ch0_seen);
    check("skip_channel ch0 beats left", 3, src_q[0].size());
    @(posedge clk);
    src_q[0].delete();
    compare_sink("skip_channel");
    finish_test("skip_channel", err0);
  endtask

  task automatic empty_start_test();
    int err0, e0;
    err0 = errors;
    cur_test = "empty_start";
    e0 = cnt_error;
    busy_seen = 1'b0;
    @(posedge clk);
    // Beats that a wrongly started lane would forward
    queue_channel(0, 0, 2, 1'b0, 1'b0);
    queue_channel(0, 1, 2, 1'b0, 1'b1);
    queue_channel(1, 0, 2, 1'b0, 1'b0);
    queue_channel(1, 1, 2, 1'b0, 1'b1);
    start_op(2'b00, 2'b11);
    repeat (4) @(posedge clk);
    check("empty_start batch error", 1, cnt_error - e0);
    start_op(2'b01, 2'b00);
    repeat (4) @(posedge clk);
    check("empty_start channel error", 2, cnt_error - e0);
    check("empty_start busy", 0, busy_seen);
    check("empty_start output beats", 0, sink_q.size());
    for (int k = 0; k < NS; k++) src_q[k].delete();
    finish_test("empty_start", err0);
  endtask

  task automatic interrupt_test();
    int err0, e0, c0;
    err0 = errors;
    cur_test = "interrupt";
    e0 = cnt_error;
    @(posedge clk);
    queue_channel(0, 0, 5, 1'b0, 1'b0);
    queue_channel(0, 1, 5, 1'b0, 1'b1);
    bp_mode = 2;
    start_op(2'b01, 2'b11);
    repeat (2) @(negedge clk);
    check("interrupt busy before", 1, operation_busy);
    interrupt = 1'b1;
    @(negedge clk);
    interrupt = 1'b0;
    repeat (2) @(posedge clk);
    check("interrupt error", 1, cnt_error - e0);
    check("interrupt busy after", 0, operation_busy);
    for (int k = 0; k < NS; k++) src_q[k].delete();
    sink_q.delete();
    bp_mode = 0;
    c0 = cnt_complete;
    queue_channel(0, 0, 2, 1'b1, 1'b0);
    queue_channel(0, 1, 2, 1'b1, 1'b1);
    queue_channel(1, 0, 3, 1'b1, 1'b0);
    queue_channel(1, 1, 1, 1'b1, 1'b1);
    start_op(2'b11, 2'b11);
    wait_complete(c0);
    compare_sink("interrupt");
    finish_test("interrupt", err0);
  endtask

  initial begin
    rst = 1'b1;
    operation_start = 1'b0;
    use_channels = '0;
    use_batch = '0;
    interrupt = 1'b0;
    s_tdata = '0;
    s_tkeep = '0;
    s_tvalid = '0;
    s_tlast = '0;
    s_tid = '0;
    m_tready = 1'b1;
    bp_mode = 0;
    cur_test = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("reset busy", 0, operation_busy);
    check("reset complete", 0, operation_complete);
    check("reset error", 0, operation_error);
    single_lane_test();
    both_lanes_test();
    backpressure_test();
    skip_channel_test();
    empty_start_test();
    interrupt_test();
    $display("%0d of %0d tests passed, %0d check errors", tests_passed, tests_run, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- lane_arb_mux.sv
`timescale 1ns/1ps
`include "pkt_join_cfg.svh"

module lane_arb_mux (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [`PJ_BATCH*`PJ_DATA_W-1:0]   lane_tdata,
  input  logic [`PJ_BATCH*`PJ_KEEP_W-1:0]   lane_tkeep,
  input  logic [`PJ_BATCH-1:0]              lane_tvalid,
  input  logic [`PJ_BATCH-1:0]              lane_tlast,
  input  logic [`PJ_BATCH*`PJ_ID_W-1:0]     lane_tid,
  output logic [`PJ_BATCH-1:0]              lane_tready,
  output logic [`PJ_DATA_W-1:0]             m_tdata,
  output logic [`PJ_KEEP_W-1:0]             m_tkeep,
  output logic                              m_tvalid,
  output logic                              m_tlast,
  output logic [`PJ_MID_W-1:0]              m_tid,
  input  logic                              m_tready
);

  logic [`PJ_LANE_W-1:0] grant;
  logic                  in_pkt;
  logic [`PJ_LANE_W-1:0] low_valid;
  logic [`PJ_LANE_W-1:0] sel;

  // Fixed priority, lane 0 first
  always_comb begin
    low_valid = '0;
    for (int i = `PJ_BATCH - 1; i >= 0; i--) begin
      if (lane_tvalid[i]) begin
        low_valid = `PJ_LANE_W'(i);
      end
    end
  end

  assign sel = in_pkt ? grant : low_valid;

  assign m_tdata  = lane_tdata[sel*`PJ_DATA_W +: `PJ_DATA_W];
  assign m_tkeep  = lane_tkeep[sel*`PJ_KEEP_W +: `PJ_KEEP_W];
  assign m_tvalid = lane_tvalid[sel];
  assign m_tlast  = lane_tlast[sel];
  // Lane index goes above the lane's own id
  assign m_tid    = {sel, lane_tid[sel*`PJ_ID_W +: `PJ_ID_W]};

  always_comb begin
    lane_tready      = '0;
    lane_tready[sel] = m_tready;
  end

  // Grant locks once a beat is presented and frees after the tlast beat moves
  always_ff @(posedge clk) begin
    if (rst) begin
      grant  <= '0;
      in_pkt <= 1'b0;
    end else if (m_tvalid) begin
      grant  <= sel;
      in_pkt <= !(m_tready && m_tlast);
    end
  end

endmodule

//--- lane_joiner.sv
`timescale 1ns/1ps
`include "pkt_join_cfg.svh"

module lane_joiner import pkt_join_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 lane_start,
  input  logic                                 lane_abort,
  input  logic [`PJ_CHANNELS-1:0]              use_channels,
  input  logic [`PJ_CHANNELS*`PJ_DATA_W-1:0]   s_tdata,
  input  logic [`PJ_CHANNELS*`PJ_KEEP_W-1:0]   s_tkeep,
  input  logic [`PJ_CHANNELS-1:0]              s_tvalid,
  input  logic [`PJ_CHANNELS-1:0]              s_tlast,
  input  logic [`PJ_CHANNELS*`PJ_ID_W-1:0]     s_tid,
  output logic [`PJ_CHANNELS-1:0]              s_tready,
  output logic [`PJ_DATA_W-1:0]                lane_tdata,
  output logic [`PJ_KEEP_W-1:0]                lane_tkeep,
  output logic                                 lane_tvalid,
  output logic                                 lane_tlast,
  output logic [`PJ_ID_W-1:0]                  lane_tid,
  input  logic                                 lane_tready,
  output lane_state_e                          lane_state,
  output logic                                 lane_fault
);

  localparam int CH_W = (`PJ_CHANNELS > 1) ? $clog2(`PJ_CHANNELS) : 1;

  lane_state_e             state;
  logic [`PJ_CHANNELS-1:0] chan_mask;
  logic [CH_W-1:0]         cur_ch;
  logic [CH_W-1:0]         first_ch;
  logic [CH_W-1:0]         next_ch;
  logic                    has_next;
  logic                    sending;
  logic                    beat;

  // Lowest channel in the incoming selection
  always_comb begin
    first_ch = '0;
    for (int i = `PJ_CHANNELS - 1; i >= 0; i--) begin
      if (use_channels[i]) begin
        first_ch = CH_W'(i);
      end
    end
  end

  // Next selected channel above the current one, if any
  always_comb begin
    next_ch  = cur_ch;
    has_next = 1'b0;
    for (int i = `PJ_CHANNELS - 1; i >= 0; i--) begin
      if (chan_mask[i] && (i > int'(cur_ch))) begin
        next_ch  = CH_W'(i);
        has_next = 1'b1;
      end
    end
  end

  assign sending = (state == SEND);

  // Zero-latency path from the current channel
  assign lane_tdata  = s_tdata[cur_ch*`PJ_DATA_W +: `PJ_DATA_W];
  assign lane_tkeep  = s_tkeep[cur_ch*`PJ_KEEP_W +: `PJ_KEEP_W];
  assign lane_tid    = s_tid[cur_ch*`PJ_ID_W +: `PJ_ID_W];
  assign lane_tvalid = sending && s_tvalid[cur_ch];
  // Inner packet boundaries are hidden
  assign lane_tlast  = s_tlast[cur_ch] && !has_next;

  assign beat = lane_tvalid && lane_tready;

  always_comb begin
    s_tready         = '0;
    s_tready[cur_ch] = sending && lane_tready;
  end

  assign lane_state = state;
  assign lane_fault = lane_start && (state == IDLE) && (use_channels == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      chan_mask <= '0;
      cur_ch    <= '0;
    end else if (lane_abort) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (lane_start && (use_channels != '0)) begin
            state     <= SEND;
            chan_mask <= use_channels;
            cur_ch    <= first_ch;
          end
        end
        SEND: begin
          if (beat && s_tlast[cur_ch]) begin
            if (has_next) begin
              cur_ch <= next_ch;
            end else begin
              state <= DONE;
            end
          end
        end
        // One cycle only, the control keeps its own record
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- pkt_join_cfg.svh
`ifndef PKT_JOIN_CFG_SVH
`define PKT_JOIN_CFG_SVH

// Input channels joined by each lane
`define PJ_CHANNELS 2

// Number of joiner lanes
`define PJ_BATCH 2

// Beat payload
`define PJ_DATA_W 16
`define PJ_KEEP_W 2

// Input id width
`define PJ_ID_W 4

// Lane tag width, clog2 of the lane count but at least 1
`define PJ_LANE_W 1

// Output id carries the lane tag above the input id
`define PJ_MID_W (`PJ_ID_W + `PJ_LANE_W)

`endif

//--- pkt_join_pkg.sv
package pkt_join_pkg;

  // Lane progress as seen by the control block
  // IDLE waits for a start, SEND forwards beats,
  // DONE is held for one cycle after the final tlast
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    SEND = 2'd1,
    DONE = 2'd2
  } lane_state_e;

endpackage

//--- src.f
+incdir+.
pkt_join_pkg.sv
batch_join_ctrl.sv
lane_joiner.sv
lane_arb_mux.sv
batched_packet_joiner.sv
batched_packet_joiner_tb.sv
